// File: test/int_muldiv_testdata.txt
// columns: fn (0 mul, 1 div, 2 divu), a, b, expected upper 32, expected lower 32
// divide results hold the remainder in the upper word and the quotient in the lower
0 00000003 00000005 00000000 0000000F
0 FFFFFFFD 00000007 FFFFFFFF FFFFFFEB
0 00000000 12345678 00000000 00000000
0 00000001 FFFFFFFF FFFFFFFF FFFFFFFF
0 80000000 80000000 40000000 00000000
0 80000000 00000001 FFFFFFFF 80000000
0 80000000 FFFFFFFF 00000000 80000000
0 7FFFFFFF 7FFFFFFF 3FFFFFFF 00000001
0 FFFFFFFF FFFFFFFF 00000000 00000001
0 00012345 FFFFFFF0 FFFFFFFF FFEDCBB0
0 0000FFFF 0000FFFF 00000000 FFFE0001
0 7FFFFFFF 80000000 C0000000 80000000
1 00000014 00000003 00000002 00000006
1 FFFFFFEC 00000003 FFFFFFFE FFFFFFFA
1 00000014 FFFFFFFD 00000002 FFFFFFFA
1 FFFFFFEC FFFFFFFD FFFFFFFE 00000006
1 80000000 FFFFFFFF 00000000 80000000
1 00000007 00000000 00000007 FFFFFFFF
1 FFFFFFF9 00000000 FFFFFFF9 00000001
1 80000000 00000002 00000000 C0000000
1 00000007 80000000 00000007 00000000
1 80000000 80000000 00000000 00000001
2 00000064 00000007 00000002 0000000E
2 FFFFFFFF 00000010 0000000F 0FFFFFFF
2 12345678 00000000 12345678 FFFFFFFF
2 FFFFFFFE FFFFFFFF FFFFFFFE 00000000
2 80000000 FFFFFFFF 80000000 00000000
2 FFFFFFFF FFFFFFFF 00000000 00000001
2 00000000 00000005 00000000 00000000
2 DEADBEEF 00010000 0000BEEF 0000DEAD

// File: build.f
common/imuldiv_data_pkg.sv
common/imuldiv_ctrl_pkg.sv
mul/int_mul_dpath.sv
mul/int_mul_ctrl.sv
div/int_div_dpath.sv
div/int_div_ctrl.sv
logic/int_muldiv_iterative.sv
test/int_muldiv_tb.sv

// File: test/int_muldiv_tb.sv
// drives int_muldiv_iterative from the vector file, one operation at a time
// random response stalls of 0 to 3 cycles add back-pressure on resp_rdy
// the vector file must hold exactly NUM_VEC lines of five hex words

module int_muldiv_tb;

  localparam int NUM_VEC      = 30;
  localparam int FIELDS       = 5;
  localparam int RESET_CYCLES = 10;
  localparam int MAX_STALL    = 3;
  localparam int LATENCY      = 33;
  // per vector the latency and worst stall plus request and transfer overhead
  localparam int MAX_CYCLES   = NUM_VEC * (LATENCY + MAX_STALL + 4) + RESET_CYCLES;

  logic                       clk;
  logic                       reset;
  imuldiv_ctrl_pkg::fn_t      req_fn;
  imuldiv_data_pkg::operand_t req_a;
  imuldiv_data_pkg::operand_t req_b;
  logic                       req_val;
  logic                       req_rdy;
  imuldiv_data_pkg::result_t  resp_result;
  logic                       resp_val;
  logic                       resp_rdy;

  // fn, a, b, expected upper half, expected lower half per vector
  logic [31:0] vec_mem [0:NUM_VEC*FIELDS-1];

  int cycle_count = 0;
  int error_count = 0;
  int check_count = 0;

  int_muldiv_iterative i_int_muldiv_iterative (
    .clk         (clk),
    .reset       (reset),
    .req_fn      (req_fn),
    .req_a       (req_a),
    .req_b       (req_b),
    .req_val     (req_val),
    .req_rdy     (req_rdy),
    .resp_result (resp_result),
    .resp_val    (resp_val),
    .resp_rdy    (resp_rdy)
  );

  always #5 clk = ~clk;

  // watchdog ends the run if a response never arrives
  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count > MAX_CYCLES) begin
      $display("run timed out after %0d cycles waiting for a response", cycle_count);
      $display("Simulation finished: FAIL");
      $finish;
    end
  end

  // ----------------------------------------------------------
  // compare tasks
  // ----------------------------------------------------------

  task automatic check_result(input string what, input imuldiv_data_pkg::result_t got,
                              input imuldiv_data_pkg::result_t exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("MISMATCH at %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_flag(input string what, input logic got, input logic exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("MISMATCH at %0t: %s got %b expected %b", $time, what, got, exp);
    end
  endtask

  // ----------------------------------------------------------
  // request and response handshakes
  // ----------------------------------------------------------

  // returns after the accepting edge with req_val already dropped
  task automatic send_request(input imuldiv_ctrl_pkg::fn_t fn,
                              input imuldiv_data_pkg::operand_t a,
                              input imuldiv_data_pkg::operand_t b);
    @(posedge clk);
    req_fn  <= fn;
    req_a   <= a;
    req_b   <= b;
    req_val <= 1'b1;
    @(negedge clk);
    while (req_rdy !== 1'b1) begin
      @(negedge clk);
    end
    @(posedge clk);
    req_val <= 1'b0;
  endtask

  // waits for resp_val and keeps resp_rdy low for stall_cycles edges before taking it
  task automatic take_response(input imuldiv_data_pkg::result_t expected,
                               input int stall_cycles);
    // zero stall keeps ready up before valid arrives
    if (stall_cycles == 0) begin
      resp_rdy <= 1'b1;
    end
    @(negedge clk);
    while (resp_val !== 1'b1) begin
      check_flag("req_rdy while busy", req_rdy, 1'b0);
      @(negedge clk);
    end
    check_result("resp_result", resp_result, expected);
    check_flag("req_rdy with response pending", req_rdy, 1'b0);
    if (stall_cycles > 0) begin
      repeat (stall_cycles - 1) begin
        @(posedge clk);
        @(negedge clk);
        check_flag("resp_val under stall", resp_val, 1'b1);
        check_flag("req_rdy under stall", req_rdy, 1'b0);
        check_result("resp_result under stall", resp_result, expected);
      end
      @(posedge clk);
      resp_rdy <= 1'b1;
      @(negedge clk);
      check_flag("resp_val before transfer", resp_val, 1'b1);
      check_flag("req_rdy before transfer", req_rdy, 1'b0);
      check_result("resp_result at transfer", resp_result, expected);
    end
    // this edge transfers the response
    @(posedge clk);
    resp_rdy <= 1'b0;
    @(negedge clk);
    // a second response here would mean a repeated operation
    check_flag("resp_val after transfer", resp_val, 1'b0);
    check_flag("req_rdy after transfer", req_rdy, 1'b1);
  endtask

  task automatic run_vector(input int idx);
    imuldiv_ctrl_pkg::fn_t      fn;
    imuldiv_data_pkg::operand_t a;
    imuldiv_data_pkg::operand_t b;
    imuldiv_data_pkg::result_t  expected;
    int                         errors_before;
    int                         stall_cycles;
    fn            = imuldiv_ctrl_pkg::fn_t'(vec_mem[idx*FIELDS][1:0]);
    a             = vec_mem[idx*FIELDS+1];
    b             = vec_mem[idx*FIELDS+2];
    expected      = {vec_mem[idx*FIELDS+3], vec_mem[idx*FIELDS+4]};
    errors_before = error_count;
    if ($isunknown({vec_mem[idx*FIELDS], a, b, expected})) begin
      error_count++;
      $display("vector %0d is missing or unreadable in the test data file", idx);
      return;
    end
    stall_cycles = $urandom % (MAX_STALL + 1);
    send_request(fn, a, b);
    take_response(expected, stall_cycles);
    $display("vector %0d fn %0d a %h b %h stall %0d: %s", idx, fn, a, b, stall_cycles,
             (error_count == errors_before) ? "ok" : "failed");
  endtask

  // ----------------------------------------------------------
  // main sequence
  // ----------------------------------------------------------

  initial begin
    clk        = 1'b0;
    reset      = 1'b1;
    req_fn     = imuldiv_ctrl_pkg::FN_MUL;
    req_a      = '0;
    req_b      = '0;
    req_val    = 1'b0;
    resp_rdy   = 1'b0;
    void'($urandom(32'h2725));
    $readmemh("test/int_muldiv_testdata.txt", vec_mem);

    repeat (RESET_CYCLES) @(posedge clk);
    reset <= 1'b0;
    @(negedge clk);
    check_flag("req_rdy after reset", req_rdy, 1'b1);
    check_flag("resp_val after reset", resp_val, 1'b0);
    $display("reset state: %s", (error_count == 0) ? "ok" : "failed");

    for (int i = 0; i < NUM_VEC; i++) begin
      run_vector(i);
    end

    $display("%0d vectors, %0d checks, %0d errors", NUM_VEC, check_count, error_count);
    if (error_count == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

// File: logic/int_muldiv_iterative.sv
// iterative mul/div unit, one operation in flight across both units
// fn code 2'b11 is accepted and dropped with no response

module int_muldiv_iterative (
  input  logic                       clk,
  input  logic                       reset,

  input  imuldiv_ctrl_pkg::fn_t      req_fn,
  input  imuldiv_data_pkg::operand_t req_a,
  input  imuldiv_data_pkg::operand_t req_b,
  input  logic                       req_val,
  output logic                       req_rdy,

  output imuldiv_data_pkg::result_t  resp_result,
  output logic                       resp_val,
  input  logic                       resp_rdy
);

  // request steering
  logic req_go;
  logic fn_is_mul;
  logic fn_is_div;
  logic owner_val;
  logic owner_div;
  logic resp_go;

  // multiplier wires
  logic                      mul_req_val;
  logic                      mul_req_rdy;
  logic                      mul_resp_val;
  logic                      mul_resp_rdy;
  logic                      mul_cnt_zero;
  logic                      mul_b_lsb;
  logic                      mul_sign;
  logic                      mul_a_en;
  logic                      mul_a_sel;
  logic                      mul_b_en;
  logic                      mul_b_sel;
  logic                      mul_result_en;
  logic                      mul_result_sel;
  logic                      mul_add_sel;
  logic                      mul_cntr_sel;
  logic                      mul_sign_en;
  logic                      mul_negate;
  imuldiv_data_pkg::result_t mul_result;

  // divider wires
  logic                      div_req_val;
  logic                      div_req_rdy;
  logic                      div_resp_val;
  logic                      div_resp_rdy;
  logic                      div_is_signed;
  logic                      div_cnt_zero;
  logic                      div_diff_nonneg;
  logic                      div_load;
  logic                      div_step;
  logic                      div_keep_diff;
  imuldiv_data_pkg::result_t div_result;

  // ---------------------------------------------------------
  // request side
  // ---------------------------------------------------------

  assign fn_is_mul = (req_fn == imuldiv_ctrl_pkg::FN_MUL);
  assign fn_is_div = (req_fn == imuldiv_ctrl_pkg::FN_DIV) ||
                     (req_fn == imuldiv_ctrl_pkg::FN_DIVU);

  // ready only with both units idle and nothing left to hand back
  assign req_rdy = mul_req_rdy & div_req_rdy & ~owner_val;
  assign req_go  = req_val & req_rdy;

  assign mul_req_val   = req_go & fn_is_mul;
  assign div_req_val   = req_go & fn_is_div;
  assign div_is_signed = (req_fn != imuldiv_ctrl_pkg::FN_DIVU);

  // ---------------------------------------------------------
  // owner record
  // ---------------------------------------------------------

  assign resp_go = resp_val & resp_rdy;

  always_ff @(posedge clk) begin
    if (reset) begin
      owner_val <= 1'b0;
      owner_div <= 1'b0;
    end else if (req_go && (fn_is_mul || fn_is_div)) begin
      owner_val <= 1'b1;
      owner_div <= fn_is_div;
    end else if (resp_go) begin
      owner_val <= 1'b0;
    end
  end

  // ---------------------------------------------------------
  // response side
  // ---------------------------------------------------------

  // owning unit alone sees the outside ready
  assign mul_resp_rdy = resp_rdy & owner_val & ~owner_div;
  assign div_resp_rdy = resp_rdy & owner_val & owner_div;

  assign resp_val    = owner_val & (owner_div ? div_resp_val : mul_resp_val);
  assign resp_result = owner_div ? div_result : mul_result;

  // ---------------------------------------------------------
  // multiplier
  // ---------------------------------------------------------

  int_mul_ctrl i_int_mul_ctrl (
    .clk             (clk),
    .reset           (reset),
    .req_val         (mul_req_val),
    .req_rdy         (mul_req_rdy),
    .resp_val        (mul_resp_val),
    .resp_rdy        (mul_resp_rdy),
    .counter_is_zero (mul_cnt_zero),
    .b_lsb           (mul_b_lsb),
    .sign            (mul_sign),
    .a_en            (mul_a_en),
    .a_sel           (mul_a_sel),
    .b_en            (mul_b_en),
    .b_sel           (mul_b_sel),
    .result_en       (mul_result_en),
    .result_sel      (mul_result_sel),
    .add_sel         (mul_add_sel),
    .cntr_sel        (mul_cntr_sel),
    .sign_en         (mul_sign_en),
    .negate          (mul_negate)
  );

  int_mul_dpath i_int_mul_dpath (
    .clk             (clk),
    .reset           (reset),
    .req_a           (req_a),
    .req_b           (req_b),
    .a_en            (mul_a_en),
    .a_sel           (mul_a_sel),
    .b_en            (mul_b_en),
    .b_sel           (mul_b_sel),
    .result_en       (mul_result_en),
    .result_sel      (mul_result_sel),
    .add_sel         (mul_add_sel),
    .cntr_sel        (mul_cntr_sel),
    .sign_en         (mul_sign_en),
    .negate          (mul_negate),
    .counter_is_zero (mul_cnt_zero),
    .b_lsb           (mul_b_lsb),
    .sign            (mul_sign),
    .result          (mul_result)
  );

  // ---------------------------------------------------------
  // divider
  // ---------------------------------------------------------

  int_div_ctrl i_int_div_ctrl (
    .clk             (clk),
    .reset           (reset),
    .req_val         (div_req_val),
    .req_rdy         (div_req_rdy),
    .resp_val        (div_resp_val),
    .resp_rdy        (div_resp_rdy),
    .counter_is_zero (div_cnt_zero),
    .diff_nonneg     (div_diff_nonneg),
    .load            (div_load),
    .step            (div_step),
    .keep_diff       (div_keep_diff)
  );

  int_div_dpath i_int_div_dpath (
    .clk             (clk),
    .reset           (reset),
    .req_a           (req_a),
    .req_b           (req_b),
    .is_signed       (div_is_signed),
    .load            (div_load),
    .step            (div_step),
    .keep_diff       (div_keep_diff),
    .counter_is_zero (div_cnt_zero),
    .diff_nonneg     (div_diff_nonneg),
    .result          (div_result)
  );

endmodule

// File: div/int_div_ctrl.sv
// divider controller, same handshake and latency as the multiplier
// sign handling lives entirely in the datapath

module int_div_ctrl (
  input  logic clk,
  input  logic reset,

  input  logic req_val,
  output logic req_rdy,
  output logic resp_val,
  input  logic resp_rdy,

  // status from the datapath
  input  logic counter_is_zero,
  input  logic diff_nonneg,

  // controls to the datapath
  output logic load,
  output logic step,
  output logic keep_diff
);

  imuldiv_ctrl_pkg::iter_state_t state;
  imuldiv_ctrl_pkg::iter_state_t state_next;

  // ---------------------------------------------------------
  // state register
  // ---------------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= imuldiv_ctrl_pkg::IDLE;
    end else begin
      state <= state_next;
    end
  end

  always_comb begin
    state_next = state;
    case (state)
      imuldiv_ctrl_pkg::IDLE: begin
        if (req_val) begin
          state_next = imuldiv_ctrl_pkg::CALC;
        end
      end
      // counter at zero means this cycle runs the last step
      imuldiv_ctrl_pkg::CALC: begin
        if (counter_is_zero) begin
          state_next = imuldiv_ctrl_pkg::DONE;
        end
      end
      imuldiv_ctrl_pkg::DONE: begin
        if (resp_rdy) begin
          state_next = imuldiv_ctrl_pkg::IDLE;
        end
      end
      default: state_next = imuldiv_ctrl_pkg::IDLE;
    endcase
  end

  // ---------------------------------------------------------
  // outputs
  // ---------------------------------------------------------

  always_comb begin
    req_rdy   = 1'b0;
    resp_val  = 1'b0;
    load      = 1'b0;
    step      = 1'b0;
    keep_diff = 1'b0;
    case (state)
      imuldiv_ctrl_pkg::IDLE: begin
        req_rdy = 1'b1;
        load    = req_val;
      end
      imuldiv_ctrl_pkg::CALC: begin
        step = 1'b1;
        // restore by simply not keeping a negative difference
        keep_diff = diff_nonneg;
      end
      imuldiv_ctrl_pkg::DONE: begin
        resp_val = 1'b1;
      end
      default: begin
        req_rdy = 1'b0;
      end
    endcase
  end

endmodule

// File: div/int_div_dpath.sv
// restoring divider datapath, one quotient bit per step
// divide by zero is not trapped and falls out of the algorithm

module int_div_dpath (
  input  logic                       clk,
  input  logic                       reset,

  input  imuldiv_data_pkg::operand_t req_a,
  input  imuldiv_data_pkg::operand_t req_b,
  input  logic                       is_signed,

  input  logic                       load,
  input  logic                       step,
  input  logic                       keep_diff,

  output logic                       counter_is_zero,
  output logic                       diff_nonneg,
  output imuldiv_data_pkg::result_t  result
);

  localparam int OW  = imuldiv_data_pkg::OPERAND_W;
  localparam int RW  = imuldiv_data_pkg::RESULT_W;

  logic                       a_neg;
  logic                       b_neg;
  imuldiv_data_pkg::operand_t a_mag;
  imuldiv_data_pkg::operand_t b_mag;
  imuldiv_data_pkg::operand_t divisor;
  imuldiv_data_pkg::result_t  rq;
  imuldiv_data_pkg::result_t  shifted;
  logic [OW+1:0]              diff;
  imuldiv_data_pkg::count_t   counter;
  logic                       sign_a;
  logic                       sign_b;
  imuldiv_data_pkg::operand_t quo_fix;
  imuldiv_data_pkg::operand_t rem_fix;

  // ---------------------------------------------------------
  // operand magnitudes
  // ---------------------------------------------------------

  // unsigned divide sees both operands as nonnegative
  assign a_neg = is_signed & req_a[OW-1];
  assign b_neg = is_signed & req_b[OW-1];
  assign a_mag = a_neg ? -req_a : req_a;
  assign b_mag = b_neg ? -req_b : req_b;

  // ---------------------------------------------------------
  // trial subtraction
  // ---------------------------------------------------------

  // rq holds partial remainder above, dividend bits and quotient below
  assign shifted = rq << 1;

  // shifted remainder can need 33 bits when the divisor is above 2^31,
  // so the subtract is one bit wider still to keep a borrow bit
  assign diff        = {1'b0, rq[RW-1:OW-1]} - {2'b00, divisor};
  assign diff_nonneg = ~diff[OW+1];

  always_ff @(posedge clk) begin
    if (load) begin
      rq      <= imuldiv_data_pkg::result_t'(a_mag);
      divisor <= b_mag;
    end else if (step) begin
      // kept difference always fits 32 bits, quotient bit enters at 0
      if (keep_diff) begin
        rq <= {diff[OW-1:0], shifted[OW-1:1], 1'b1};
      end else begin
        rq <= shifted;
      end
    end
  end

  // ---------------------------------------------------------
  // counter and sign flags
  // ---------------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      counter <= imuldiv_data_pkg::LAST_ITER;
    end else if (load) begin
      counter <= imuldiv_data_pkg::LAST_ITER;
    end else if (step) begin
      counter <= counter - 1'b1;
    end
  end

  assign counter_is_zero = (counter == '0);

  always_ff @(posedge clk) begin
    if (reset) begin
      sign_a <= 1'b0;
      sign_b <= 1'b0;
    end else if (load) begin
      sign_a <= a_neg;
      sign_b <= b_neg;
    end
  end

  // ---------------------------------------------------------
  // sign correction
  // ---------------------------------------------------------

  // quotient negative when signs differ, remainder follows dividend
  assign quo_fix = (sign_a ^ sign_b) ? -rq[OW-1:0] : rq[OW-1:0];
  assign rem_fix = sign_a ? -rq[RW-1:OW] : rq[RW-1:OW];

  assign result = {rem_fix, quo_fix};

endmodule

// File: mul/int_mul_ctrl.sv
// multiplier controller, one operation in flight at a time
// result stays valid in DONE until resp_rdy is seen

module int_mul_ctrl (
  input  logic clk,
  input  logic reset,

  input  logic req_val,
  output logic req_rdy,
  output logic resp_val,
  input  logic resp_rdy,

  // status from the datapath
  input  logic counter_is_zero,
  input  logic b_lsb,
  input  logic sign,

  // enables and selects to the datapath
  output logic a_en,
  output logic a_sel,
  output logic b_en,
  output logic b_sel,
  output logic result_en,
  output logic result_sel,
  output logic add_sel,
  output logic cntr_sel,
  output logic sign_en,
  output logic negate
);

  imuldiv_ctrl_pkg::iter_state_t state;
  imuldiv_ctrl_pkg::iter_state_t state_next;

  // ---------------------------------------------------------
  // state register
  // ---------------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= imuldiv_ctrl_pkg::IDLE;
    end else begin
      state <= state_next;
    end
  end

  always_comb begin
    state_next = state;
    case (state)
      imuldiv_ctrl_pkg::IDLE: begin
        if (req_val) begin
          state_next = imuldiv_ctrl_pkg::CALC;
        end
      end
      // leave on the edge that finishes the last iteration
      imuldiv_ctrl_pkg::CALC: begin
        if (counter_is_zero) begin
          state_next = imuldiv_ctrl_pkg::DONE;
        end
      end
      imuldiv_ctrl_pkg::DONE: begin
        if (resp_rdy) begin
          state_next = imuldiv_ctrl_pkg::IDLE;
        end
      end
      default: state_next = imuldiv_ctrl_pkg::IDLE;
    endcase
  end

  // ---------------------------------------------------------
  // outputs
  // ---------------------------------------------------------

  always_comb begin
    req_rdy    = 1'b0;
    resp_val   = 1'b0;
    a_en       = 1'b0;
    a_sel      = 1'b0;
    b_en       = 1'b0;
    b_sel      = 1'b0;
    result_en  = 1'b0;
    result_sel = 1'b0;
    add_sel    = 1'b0;
    cntr_sel   = 1'b0;
    sign_en    = 1'b0;
    negate     = 1'b0;
    case (state)
      imuldiv_ctrl_pkg::IDLE: begin
        req_rdy = 1'b1;
        // load magnitudes, clear accumulator, capture sign
        if (req_val) begin
          a_en      = 1'b1;
          b_en      = 1'b1;
          result_en = 1'b1;
          sign_en   = 1'b1;
        end
      end
      imuldiv_ctrl_pkg::CALC: begin
        // shift both operands every cycle
        a_en       = 1'b1;
        a_sel      = 1'b1;
        b_en       = 1'b1;
        b_sel      = 1'b1;
        result_en  = 1'b1;
        result_sel = 1'b1;
        add_sel    = b_lsb;
        cntr_sel   = 1'b1;
      end
      imuldiv_ctrl_pkg::DONE: begin
        resp_val = 1'b1;
        negate   = sign;
      end
      default: begin
        req_rdy = 1'b0;
      end
    endcase
  end

endmodule

// File: mul/int_mul_dpath.sv
// shift-and-add multiplier datapath on operand magnitudes
// operands are always treated as signed, no unsigned multiply

module int_mul_dpath (
  input  logic                       clk,
  input  logic                       reset,

  input  imuldiv_data_pkg::operand_t req_a,
  input  imuldiv_data_pkg::operand_t req_b,

  input  logic                       a_en,
  input  logic                       a_sel,
  input  logic                       b_en,
  input  logic                       b_sel,
  input  logic                       result_en,
  input  logic                       result_sel,
  input  logic                       add_sel,
  input  logic                       cntr_sel,
  input  logic                       sign_en,
  input  logic                       negate,

  output logic                       counter_is_zero,
  output logic                       b_lsb,
  output logic                       sign,
  output imuldiv_data_pkg::result_t  result
);

  localparam int MSB = imuldiv_data_pkg::OPERAND_W - 1;

  imuldiv_data_pkg::operand_t a_mag;
  imuldiv_data_pkg::operand_t b_mag;
  imuldiv_data_pkg::result_t  a_reg;
  imuldiv_data_pkg::result_t  a_next;
  imuldiv_data_pkg::operand_t b_reg;
  imuldiv_data_pkg::operand_t b_next;
  imuldiv_data_pkg::result_t  acc_reg;
  imuldiv_data_pkg::result_t  add_out;
  imuldiv_data_pkg::result_t  acc_next;
  imuldiv_data_pkg::count_t   counter;
  logic                       sign_reg;

  // ---------------------------------------------------------
  // operand magnitudes
  // ---------------------------------------------------------

  // most negative operand maps to 2^31, which still fits unsigned
  assign a_mag = req_a[MSB] ? -req_a : req_a;
  assign b_mag = req_b[MSB] ? -req_b : req_b;

  // multiplicand moves left one place per iteration
  assign a_next = a_sel ? (a_reg << 1) : imuldiv_data_pkg::result_t'(a_mag);
  // multiplier moves right so bit 0 always holds the current digit
  assign b_next = b_sel ? (b_reg >> 1) : b_mag;
  assign b_lsb  = b_reg[0];

  // ---------------------------------------------------------
  // accumulator
  // ---------------------------------------------------------

  // add only when the controller saw b_lsb set
  assign add_out  = add_sel ? (acc_reg + a_reg) : acc_reg;
  // result_sel low clears the accumulator at accept
  assign acc_next = result_sel ? add_out : '0;

  always_ff @(posedge clk) begin
    if (a_en) begin
      a_reg <= a_next;
    end
    if (b_en) begin
      b_reg <= b_next;
    end
    if (result_en) begin
      acc_reg <= acc_next;
    end
  end

  // ---------------------------------------------------------
  // counter and sign
  // ---------------------------------------------------------

  // reloads every cycle outside CALC, counts down inside it
  always_ff @(posedge clk) begin
    if (reset) begin
      counter <= imuldiv_data_pkg::LAST_ITER;
    end else if (cntr_sel) begin
      counter <= counter - 1'b1;
    end else begin
      counter <= imuldiv_data_pkg::LAST_ITER;
    end
  end

  assign counter_is_zero = (counter == '0);

  // product is negative when exactly one operand is
  always_ff @(posedge clk) begin
    if (reset) begin
      sign_reg <= 1'b0;
    end else if (sign_en) begin
      sign_reg <= req_a[MSB] ^ req_b[MSB];
    end
  end

  assign sign = sign_reg;

  // two's complement only while the controller asks for it
  assign result = negate ? -acc_reg : acc_reg;

endmodule

// File: common/imuldiv_ctrl_pkg.sv
// function codes seen on the request port and the state encoding
// shared by both iterative unit controllers

package imuldiv_ctrl_pkg;

  // ---------------------------------------------------------
  // request function codes
  // ---------------------------------------------------------

  typedef logic [1:0] fn_t;

  // signed 32x32 -> 64 multiply
  localparam fn_t FN_MUL  = 2'b00;
  // signed divide, remainder in upper half, quotient in lower half
  localparam fn_t FN_DIV  = 2'b01;
  // unsigned divide, same result layout
  localparam fn_t FN_DIVU = 2'b10;
  // code 2'b11 is not assigned to any unit

  // ---------------------------------------------------------
  // controller state
  // ---------------------------------------------------------

  // IDLE  waiting for a request, operands load on the accepting edge
  // CALC  one iteration per cycle until the counter reaches zero
  // DONE  result valid, held until the response transfers
  typedef enum logic [1:0] {
    IDLE = 2'd0,
    CALC = 2'd1,
    DONE = 2'd2
  } iter_state_t;

endpackage

// File: common/imuldiv_data_pkg.sv
// word widths and word types shared by the multiply and divide datapaths
// operands are 32 bits wide and results pack two operand-sized halves

package imuldiv_data_pkg;

  // ---------------------------------------------------------
  // widths
  // ---------------------------------------------------------

  // one request operand
  localparam int OPERAND_W = 32;
  // full product, or remainder and quotient side by side
  localparam int RESULT_W  = 2 * OPERAND_W;
  // enough bits to count one iteration per operand bit
  localparam int COUNT_W   = $clog2(OPERAND_W);

  // ---------------------------------------------------------
  // word types
  // ---------------------------------------------------------

  typedef logic [OPERAND_W-1:0] operand_t;
  typedef logic [RESULT_W-1:0]  result_t;
  typedef logic [COUNT_W-1:0]   count_t;

  // counter value loaded at accept, counts down to zero in CALC
  // so that CALC lasts exactly OPERAND_W cycles
  localparam count_t LAST_ITER = count_t'(OPERAND_W - 1);

endpackage
